//--- dv/mem_subsys_checker.sv
`timescale 1ns/100ps
`include "mem_cfg.svh"

module mem_subsys_checker (
	input logic                   clk,
	input logic                   rst,
	input wb_pkg::wb_req_t        bus_req,
	input wb_pkg::wb_rsp_t        bus_rsp,
	input mem_map_pkg::bank_req_t bank_req [`MEM_NUM_BANKS],
	input mem_map_pkg::bank_rsp_t bank_rsp [`MEM_NUM_BANKS]
);

	logic [`MEM_NUM_BANKS-1:0] valid_vec;
	logic [`MEM_NUM_BANKS-1:0] done_vec;

	// bank valids and dones gathered into vectors
	always_comb begin
		for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
			valid_vec[b] = bank_req[b].valid;
			done_vec[b]  = bank_rsp[b].done;
		end
	end

	no_ack_and_err: assert property (@(posedge clk) disable iff (rst)
		!(bus_rsp.ack && bus_rsp.err))
		else $error("ack and err are high in the same cycle");

	// reply pulses last a single cycle
	ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
		bus_rsp.ack |=> !bus_rsp.ack)
		else $error("ack held for more than one cycle");

	err_one_cycle: assert property (@(posedge clk) disable iff (rst)
		bus_rsp.err |=> !bus_rsp.err)
		else $error("err held for more than one cycle");

	reply_in_cycle: assert property (@(posedge clk) disable iff (rst)
		(bus_rsp.ack || bus_rsp.err) |-> (bus_req.cyc && bus_req.stb))
		else $error("reply given outside of an active bus cycle");

	// single item in flight, so no new bank valid while a bank still answers
	one_bank_active: assert property (@(posedge clk) disable iff (rst)
		$onehot0({valid_vec, done_vec}))
		else $error("more than one bank request or reply active at once");

endmodule

bind mem_subsys_top mem_subsys_checker checker_i (
	.clk      (clk),
	.rst      (rst),
	.bus_req  (bus_req),
	.bus_rsp  (bus_rsp),
	.bank_req (bank_req),
	.bank_rsp (bank_rsp)
);

//--- dv/tb_mem_subsys.sv
`timescale 1ns/100ps
`include "mem_cfg.svh"

module tb_mem_subsys;
	import wb_pkg::*;

	localparam int CLK_PERIOD     = 40;
	localparam int TIMEOUT_CYCLES = 20;
	localparam int MAX_ROWS       = 64;
	localparam bit EXP_ACK        = 1'b0;
	localparam bit EXP_ERR        = 1'b1;

	// one row of the stimulus table
	typedef struct {
		string                  name;
		bit                     boot;
		bit                     we;
		logic [`MEM_SEL_W-1:0]  sel;
		logic [31:0]            adr;
		logic [`MEM_DATA_W-1:0] wdat;
		bit                     exp_err;
		logic [`MEM_DATA_W-1:0] exp_rd;
		bit                     from_model;
	} row_t;

	logic    clk;
	logic    rst;
	logic    boot;
	wb_req_t bus_req;
	wb_rsp_t bus_rsp;

	row_t                   rows [MAX_ROWS];
	int                     num_rows;
	int                     errors;
	// shadow of the whole memory, indexed by word address
	logic [`MEM_DATA_W-1:0] shadow [`MEM_TOTAL_WORDS];

	mem_subsys_top dut_i (
		.clk     (clk),
		.rst     (rst),
		.boot    (boot),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	function automatic logic [`MEM_DATA_W-1:0] merge_bytes(
		input logic [`MEM_DATA_W-1:0] old_word,
		input logic [`MEM_DATA_W-1:0] new_word,
		input logic [`MEM_SEL_W-1:0]  sel
	);
		logic [`MEM_DATA_W-1:0] result;
		for (int i = 0; i < `MEM_SEL_W; i++) begin
			result[8*i +: 8] = sel[i] ? new_word[8*i +: 8] : old_word[8*i +: 8];
		end
		return result;
	endfunction

	// cycles from the sampling edge to the visible reply
	function automatic int expected_cycles(input bit is_err, input bit we,
		input logic [`MEM_SEL_W-1:0] sel);
		if (is_err) begin
			return 2;
		end
		if (we && !(&sel)) begin
			return 4;
		end
		return 3;
	endfunction

	function automatic string reply_name(input bit is_err);
		return is_err ? "err" : "ack";
	endfunction

	task automatic add_write(input string name, input bit boot_lvl,
		input logic [`MEM_SEL_W-1:0] sel, input logic [31:0] adr,
		input logic [`MEM_DATA_W-1:0] wdat, input bit exp_err);
		rows[num_rows] = '{name, boot_lvl, 1'b1, sel, adr, wdat, exp_err, '0, 1'b0};
		num_rows++;
	endtask

	task automatic add_read(input string name, input bit boot_lvl, input logic [31:0] adr,
		input bit exp_err, input logic [`MEM_DATA_W-1:0] exp_rd, input bit from_model);
		rows[num_rows] = '{name, boot_lvl, 1'b0, '1, adr, '0, exp_err, exp_rd, from_model};
		num_rows++;
	endtask

	task automatic build_table();
		// program preload while booting, then read back
		add_write("boot_wr_w0", 1, 4'hf, 32'h0000_0000, 32'h1111_0000, EXP_ACK);
		add_write("boot_wr_w1", 1, 4'hf, 32'h0000_0004, 32'h2222_0001, EXP_ACK);
		add_write("boot_wr_w2", 1, 4'hf, 32'h0000_0008, 32'h3333_0002, EXP_ACK);
		add_write("boot_wr_w63", 1, 4'hf, 32'h0000_00fc, 32'h4444_003f, EXP_ACK);
		add_read("run_rd_w0", 0, 32'h0000_0000, EXP_ACK, 32'h1111_0000, 0);
		add_read("run_rd_w1", 0, 32'h0000_0004, EXP_ACK, 32'h2222_0001, 0);
		add_read("run_rd_w2", 0, 32'h0000_0008, EXP_ACK, 32'h3333_0002, 0);
		add_read("run_rd_w63", 0, 32'h0000_00fc, EXP_ACK, 32'h4444_003f, 0);
		// instruction region is read-only after boot
		add_write("run_wr_inst_full", 0, 4'hf, 32'h0000_0004, 32'hdead_beef, EXP_ERR);
		add_write("run_wr_inst_byte", 0, 4'h2, 32'h0000_0008, 32'hcafe_f00d, EXP_ERR);
		add_read("run_rd_w1_kept", 0, 32'h0000_0004, EXP_ACK, 32'h2222_0001, 0);
		add_read("run_rd_w2_kept", 0, 32'h0000_0008, EXP_ACK, 32'h3333_0002, 0);
		// byte lane merges in the data region
		add_write("data_wr_base0", 0, 4'hf, 32'h0000_0100, $urandom(), EXP_ACK);
		add_write("data_wr_byte0", 0, 4'h1, 32'h0000_0100, $urandom(), EXP_ACK);
		add_read("data_rd_byte0", 0, 32'h0000_0100, EXP_ACK, '0, 1);
		add_write("data_wr_byte2", 0, 4'h4, 32'h0000_0100, $urandom(), EXP_ACK);
		add_read("data_rd_byte2", 0, 32'h0000_0100, EXP_ACK, '0, 1);
		add_write("data_wr_half_hi", 0, 4'hc, 32'h0000_0100, $urandom(), EXP_ACK);
		add_read("data_rd_half_hi", 0, 32'h0000_0100, EXP_ACK, '0, 1);
		add_write("data_wr_base1", 0, 4'hf, 32'h0000_0104, $urandom(), EXP_ACK);
		add_write("data_wr_half_lo", 0, 4'h3, 32'h0000_0104, $urandom(), EXP_ACK);
		add_read("data_rd_half_lo", 0, 32'h0000_0104, EXP_ACK, '0, 1);
		add_write("data_wr_fixed", 0, 4'hf, 32'h0000_0108, 32'h0102_0304, EXP_ACK);
		add_write("data_wr_fixed_b1", 0, 4'h2, 32'h0000_0108, 32'haabb_ccdd, EXP_ACK);
		add_read("data_rd_fixed", 0, 32'h0000_0108, EXP_ACK, 32'h0102_cc04, 0);
		// one word per bank, read back in reverse order
		add_write("ilv_wr_b0", 0, 4'hf, 32'h0000_0200, 32'ha0a0_0000, EXP_ACK);
		add_write("ilv_wr_b1", 0, 4'hf, 32'h0000_0204, 32'hb1b1_0001, EXP_ACK);
		add_write("ilv_wr_b2", 0, 4'hf, 32'h0000_0208, 32'hc2c2_0002, EXP_ACK);
		add_write("ilv_wr_b3", 0, 4'hf, 32'h0000_020c, 32'hd3d3_0003, EXP_ACK);
		add_read("ilv_rd_b3", 0, 32'h0000_020c, EXP_ACK, 32'hd3d3_0003, 0);
		add_read("ilv_rd_b2", 0, 32'h0000_0208, EXP_ACK, 32'hc2c2_0002, 0);
		add_read("ilv_rd_b1", 0, 32'h0000_0204, EXP_ACK, 32'hb1b1_0001, 0);
		add_read("ilv_rd_b0", 0, 32'h0000_0200, EXP_ACK, 32'ha0a0_0000, 0);
		add_write("last_wr", 0, 4'hf, 32'h0000_03fc, 32'h7e57_00ff, EXP_ACK);
		add_read("last_rd", 0, 32'h0000_03fc, EXP_ACK, 32'h7e57_00ff, 0);
		// past the last bank word
		add_read("oob_rd_first", 0, 32'h0000_0400, EXP_ERR, '0, 0);
		add_write("oob_wr_boot", 1, 4'hf, 32'h0000_0400, 32'h5555_aaaa, EXP_ERR);
		add_write("oob_wr_byte", 0, 4'h1, 32'h0000_0800, 32'h0000_0099, EXP_ERR);
		add_read("oob_rd_top", 0, 32'hffff_fffc, EXP_ERR, '0, 0);
	endtask

	task automatic run_row(input int i);
		row_t                   r;
		int                     cycles;
		int                     exp_cycles;
		int                     word;
		int                     row_errors;
		bit                     got_reply;
		bit                     got_err;
		logic [`MEM_DATA_W-1:0] got_dat;
		logic [`MEM_DATA_W-1:0] exp_dat;
		r          = rows[i];
		cycles     = 0;
		row_errors = 0;
		got_reply  = 1'b0;
		got_err    = 1'b0;
		got_dat    = '0;
		word       = r.adr[31:2];
		exp_cycles = expected_cycles(r.exp_err, r.we, r.sel);

		@(posedge clk);
		boot        <= r.boot;
		bus_req.cyc <= 1'b1;
		bus_req.stb <= 1'b1;
		bus_req.we  <= r.we;
		bus_req.sel <= r.sel;
		bus_req.adr <= r.adr;
		bus_req.dat <= r.wdat;
		// sampling edge of the decoder
		@(posedge clk);
		while (!got_reply && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
			if (bus_rsp.ack || bus_rsp.err) begin
				got_reply = 1'b1;
				got_err   = bus_rsp.err;
				got_dat   = bus_rsp.dat;
			end
		end
		@(posedge clk);
		bus_req.cyc <= 1'b0;
		bus_req.stb <= 1'b0;

		if (!got_reply) begin
			$display("%s: no ack or err within %0d cycles", r.name, TIMEOUT_CYCLES);
			row_errors++;
		end else begin
			assert (got_err == r.exp_err) else begin
				$display("[ERROR] %s: reply expected %s actual %s", r.name,
					reply_name(r.exp_err), reply_name(got_err));
				row_errors++;
			end
			assert (cycles == exp_cycles) else begin
				$display("[ERROR] %s: latency expected %0d actual %0d", r.name,
					exp_cycles, cycles);
				row_errors++;
			end
			if (!r.we) begin
				if (r.exp_err) begin
					exp_dat = '0;
				end else begin
					exp_dat = r.from_model ? shadow[word] : r.exp_rd;
				end
				assert (got_dat === exp_dat) else begin
					$display("[ERROR] %s: data expected %h actual %h", r.name,
						exp_dat, got_dat);
					row_errors++;
				end
			end
			// shadow follows acknowledged writes only
			if (r.we && !got_err && word < `MEM_TOTAL_WORDS) begin
				shadow[word] = merge_bytes(shadow[word], r.wdat, r.sel);
			end
		end
		errors += row_errors;
		$display("%-18s %s", r.name, (row_errors == 0) ? "ok" : "failed");
	endtask

	initial begin
		void'($urandom(32'h97796e2e));
		rst      = 1'b1;
		boot     = 1'b0;
		bus_req  = '0;
		num_rows = 0;
		errors   = 0;
		build_table();

		repeat (2) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < num_rows; i++) begin
			run_row(i);
		end

		$display("%0d rows run, %0d errors", num_rows, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+verilog
verilog/wb_pkg.sv
verilog/mem_map_pkg.sv
verilog/region_decoder.sv
verilog/mem_bank.sv
verilog/response_collector.sv
verilog/mem_subsys_top.sv
dv/mem_subsys_checker.sv
dv/tb_mem_subsys.sv

//--- verilog/mem_bank.sv
`timescale 1ns/100ps
`include "mem_cfg.svh"

module mem_bank (
	input  logic                   clk,
	input  logic                   rst,
	input  mem_map_pkg::bank_req_t req,
	output mem_map_pkg::bank_rsp_t rsp
);

	logic [`MEM_DATA_W-1:0]          mem [`MEM_BANK_DEPTH];
	logic [`MEM_DATA_W-1:0]          rd_q;
	logic [`MEM_BANK_DEPTH_LOG2-1:0] idx_q;
	logic [`MEM_SEL_W-1:0]           sel_q;
	logic [`MEM_DATA_W-1:0]          dat_q;
	logic [`MEM_DATA_W-1:0]          merged;
	logic                            full_sel;
	logic                            merge_pend;
	logic                            done;

	assign full_sel = &req.sel;

	// done after one cycle, or two when a byte merge is needed
	always_ff @(posedge clk) begin
		if (rst) begin
			done       <= 1'b0;
			merge_pend <= 1'b0;
		end else begin
			done       <= 1'b0;
			merge_pend <= 1'b0;
			if (merge_pend) begin
				done <= 1'b1;
			end else if (req.valid) begin
				if (req.we && !full_sel) begin
					merge_pend <= 1'b1;
				end else begin
					done <= 1'b1;
				end
			end
		end
	end

	// storage and read port
	always_ff @(posedge clk) begin
		if (merge_pend) begin
			mem[idx_q] <= merged;
		end else if (req.valid) begin
			if (!req.we) begin
				rd_q <= mem[req.idx];
			end else if (full_sel) begin
				mem[req.idx] <= req.dat;
			end else begin
				// old word lands in rd_q for the merge
				rd_q  <= mem[req.idx];
				idx_q <= req.idx;
				sel_q <= req.sel;
				dat_q <= req.dat;
			end
		end
	end

	// keep unselected bytes of the stored word
	always_comb begin
		for (int i = 0; i < `MEM_SEL_W; i++) begin
			merged[8*i +: 8] = sel_q[i] ? dat_q[8*i +: 8] : rd_q[8*i +: 8];
		end
	end

	always_comb begin
		rsp.done = done;
		rsp.dat  = rd_q;
	end

endmodule

//--- verilog/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// data path
`define MEM_DATA_W 32
`define MEM_SEL_W (`MEM_DATA_W / 8)

// interleaved banks, count must be a power of two
`define MEM_NUM_BANKS 4
`define MEM_BANK_DEPTH_LOG2 6

// derived bank geometry
`define MEM_BANK_IDX_W ($clog2(`MEM_NUM_BANKS))
`define MEM_BANK_DEPTH (1 << `MEM_BANK_DEPTH_LOG2)
`define MEM_TOTAL_WORDS (`MEM_NUM_BANKS * `MEM_BANK_DEPTH)

// word addresses below this belong to the instruction region
`define MEM_INST_END_WORD 64

`endif

//--- verilog/mem_map_pkg.sv
`include "mem_cfg.svh"

package mem_map_pkg;

	// address regions, none is past the last bank word
	typedef enum logic [1:0] {
		REGION_INST,
		REGION_DATA,
		REGION_NONE
	} region_e;

	// one request into a bank, valid for a single cycle
	typedef struct packed {
		logic                            valid;
		logic                            we;
		logic [`MEM_SEL_W-1:0]           sel;
		logic [`MEM_BANK_DEPTH_LOG2-1:0] idx;
		logic [`MEM_DATA_W-1:0]          dat;
	} bank_req_t;

	// bank reply, done pulses once per finished operation
	typedef struct packed {
		logic                   done;
		logic [`MEM_DATA_W-1:0] dat;
	} bank_rsp_t;

endpackage

//--- verilog/mem_subsys_top.sv
`timescale 1ns/100ps
`include "mem_cfg.svh"

module mem_subsys_top (
	input  logic            clk,
	input  logic            rst,
	input  logic            boot,
	input  wb_pkg::wb_req_t bus_req,
	output wb_pkg::wb_rsp_t bus_rsp
);
	import mem_map_pkg::*;

	bank_req_t                  bank_req [`MEM_NUM_BANKS];
	bank_rsp_t                  bank_rsp [`MEM_NUM_BANKS];
	logic [`MEM_BANK_IDX_W-1:0] sel_bank;
	logic                       refuse;
	logic                       reply_seen;

	region_decoder u_decoder (
		.clk        (clk),
		.rst        (rst),
		.boot       (boot),
		.bus_req    (bus_req),
		.bank_req   (bank_req),
		.sel_bank   (sel_bank),
		.refuse     (refuse),
		.reply_seen (reply_seen)
	);

	// word-interleaved banks
	for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : g_bank
		mem_bank u_bank (
			.clk (clk),
			.rst (rst),
			.req (bank_req[b]),
			.rsp (bank_rsp[b])
		);
	end

	response_collector u_collector (
		.clk        (clk),
		.rst        (rst),
		.bank_rsp   (bank_rsp),
		.sel_bank   (sel_bank),
		.refuse     (refuse),
		.bus_rsp    (bus_rsp),
		.reply_seen (reply_seen)
	);

endmodule

//--- verilog/region_decoder.sv
`timescale 1ns/100ps
`include "mem_cfg.svh"

module region_decoder (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         boot,
	input  wb_pkg::wb_req_t              bus_req,
	output mem_map_pkg::bank_req_t       bank_req [`MEM_NUM_BANKS],
	output logic [`MEM_BANK_IDX_W-1:0]   sel_bank,
	output logic                         refuse,
	input  logic                         reply_seen
);
	import mem_map_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT
	} state_e;

	state_e                 state;
	logic [29:0]            word_q;
	logic                   we_q;
	logic [`MEM_SEL_W-1:0]  sel_q;
	logic [`MEM_DATA_W-1:0] dat_q;
	region_e                region;
	logic                   permit;
	logic                   take;

	// new transaction only from idle, so a held stb is not taken twice
	assign take = (state == ST_IDLE) && bus_req.cyc && bus_req.stb;

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= ST_IDLE;
			word_q <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (take) begin
						state  <= ST_ISSUE;
						word_q <= bus_req.adr[31:2];
					end
				end
				ST_ISSUE: begin
					state <= ST_WAIT;
				end
				ST_WAIT: begin
					// back to idle once the reply pulse has gone out
					if (reply_seen) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// rest of the request, held until the reply
	always_ff @(posedge clk) begin
		if (take) begin
			we_q  <= bus_req.we;
			sel_q <= bus_req.sel;
			dat_q <= bus_req.dat;
		end
	end

	always_comb begin
		if (word_q < `MEM_INST_END_WORD) begin
			region = REGION_INST;
		end else if (word_q < `MEM_TOTAL_WORDS) begin
			region = REGION_DATA;
		end else begin
			region = REGION_NONE;
		end
	end

	// instruction region is writable only while booting
	assign permit = (region == REGION_DATA) ||
		((region == REGION_INST) && (!we_q || boot));

	assign refuse   = (state == ST_ISSUE) && !permit;
	assign sel_bank = word_q[`MEM_BANK_IDX_W-1:0];

	// low word bits pick the bank, the next bits index inside it
	always_comb begin
		for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
			bank_req[b].valid = (state == ST_ISSUE) && permit && (sel_bank == b);
			bank_req[b].we    = we_q;
			bank_req[b].sel   = sel_q;
			bank_req[b].idx   = word_q[`MEM_BANK_IDX_W +: `MEM_BANK_DEPTH_LOG2];
			bank_req[b].dat   = dat_q;
		end
	end

endmodule

//--- verilog/response_collector.sv
`timescale 1ns/100ps
`include "mem_cfg.svh"

module response_collector (
	input  logic                       clk,
	input  logic                       rst,
	input  mem_map_pkg::bank_rsp_t     bank_rsp [`MEM_NUM_BANKS],
	input  logic [`MEM_BANK_IDX_W-1:0] sel_bank,
	input  logic                       refuse,
	output wb_pkg::wb_rsp_t            bus_rsp,
	output logic                       reply_seen
);

	logic                   ack_q;
	logic                   err_q;
	logic [`MEM_DATA_W-1:0] dat_q;
	logic                   sel_done;

	// only the addressed bank can answer
	assign sel_done = bank_rsp[sel_bank].done;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
			dat_q <= '0;
		end else begin
			ack_q <= sel_done;
			err_q <= refuse;
			// zero data outside of ack
			dat_q <= sel_done ? bank_rsp[sel_bank].dat : '0;
		end
	end

	always_comb begin
		bus_rsp.ack = ack_q;
		bus_rsp.err = err_q;
		bus_rsp.dat = dat_q;
	end

	// tells the decoder the transaction has ended
	assign reply_seen = ack_q | err_q;

endmodule

//--- verilog/wb_pkg.sv
`include "mem_cfg.svh"

package wb_pkg;

	// master to slave, held stable until ack or err
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [`MEM_SEL_W-1:0]  sel;
		logic [31:0]            adr;
		logic [`MEM_DATA_W-1:0] dat;
	} wb_req_t;

	// slave to master, ack and err are single-cycle pulses
	typedef struct packed {
		logic                   ack;
		logic                   err;
		logic [`MEM_DATA_W-1:0] dat;
	} wb_rsp_t;

endpackage
